//--- Makefile
VERILATOR   ?= verilator
TOP         ?= vx_fcvt_tb
FILELIST    ?= vx_fcvt.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_MSG    ?= TB PASSED

SOURCES := $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/vx_fcvt_ctrl.sv
`timescale 1ns/100ps

module vx_fcvt_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    input  vx_fcvt_pkg::fcvt_op_e           req_op,
    input  logic [vx_fcvt_pkg::tag_bits-1:0] req_tag,
    output vx_fcvt_pkg::fcvt_ctl_t          ctl_s0,
    output logic                            s1_valid,
    output vx_fcvt_pkg::fcvt_ctl_t          ctl_s1,
    output logic                            rsp_valid,
    output logic [vx_fcvt_pkg::tag_bits-1:0] rsp_tag
);

    import vx_fcvt_pkg::*;

    logic [tag_bits-1:0] tag_s1;

    // only the signed conversion takes a two's complement magnitude
    // both counts skip rounding, and ctz searches the reversed operand
    always_comb begin
        ctl_s0.is_signed = (req_op == op_i2f_s);
        ctl_s0.is_count  = (req_op == op_clz) || (req_op == op_ctz);
        ctl_s0.reverse   = (req_op == op_ctz);
    end

    // the valid chain marks which stages hold a live request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= req_valid;
            rsp_valid <= s1_valid;
        end
    end

    // tag and control follow their request and hold while the stage is idle
    always_ff @(posedge clk) begin
        if (req_valid) begin
            tag_s1 <= req_tag;
            ctl_s1 <= ctl_s0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rsp_tag <= tag_s1;
        end
    end

    // every response must trace back to a request exactly fcvt_latency cycles earlier
    // and carry that request's tag through the load enabled stage registers
    a_rsp_has_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> $past(req_valid, fcvt_latency)
            && (rsp_tag == $past(req_tag, fcvt_latency))
    ) else $error("rsp_valid or rsp_tag does not match a request %0d cycles earlier",
                  fcvt_latency);

endmodule

//--- hdl/vx_fcvt_norm.sv
`timescale 1ns/100ps

module vx_fcvt_norm (
    input  logic                              clk,
    input  logic                              s0_valid,
    input  logic [vx_fcvt_pkg::data_bits-1:0] operand,
    input  vx_fcvt_pkg::fcvt_ctl_t            ctl,
    output vx_fcvt_pkg::norm_t                norm
);

    import vx_fcvt_pkg::*;

    logic                 neg;
    logic [data_bits-1:0] mag;
    logic [data_bits-1:0] rev;
    logic [data_bits-1:0] lzc_in;
    logic [data_bits-1:0] shifted;
    logic [lzc_bits-1:0]  lz_cnt;
    logic                 lz_valid;
    logic [cnt_bits-1:0]  count;

    // a negative signed operand is converted as its magnitude with the sign kept apart
    // 0x80000000 negates to itself, which is the right unsigned magnitude
    assign neg = ctl.is_signed & operand[data_bits-1];
    assign mag = neg ? (~operand + 1'b1) : operand;

    // trailing zeros of the operand are the leading zeros of its mirror image
    always_comb begin
        for (int i = 0; i < data_bits; i++) begin
            rev[i] = operand[data_bits-1-i];
        end
    end

    // count ops are never signed, so mag equals the raw operand for clz
    assign lzc_in = ctl.reverse ? rev : mag;

    vx_lzc #(
        .width(data_bits),
        .mode (1'b1)
    ) i_lzc (
        .in   (lzc_in),
        .cnt  (lz_cnt),
        .valid(lz_valid)
    );

    // left normalize so that the leading one lands in the MSB
    assign shifted = mag << lz_cnt;

    // an all-zero input has no first one and counts the full width
    assign count = lz_valid ? cnt_bits'(lz_cnt) : cnt_bits'(data_bits);

    // payload register, loads only for a live request
    always_ff @(posedge clk) begin
        if (s0_valid) begin
            norm.sign    <= neg;
            norm.zero    <= ~lz_valid;
            norm.lzc_cnt <= lz_cnt;
            norm.mant    <= shifted;
            norm.count   <= count;
        end
    end

    // the lzc result must bring any nonzero conversion input into normal form
    a_norm_msb: assert property (
        @(posedge clk)
        s0_valid && !ctl.is_count && (mag != '0) |=> norm.mant[data_bits-1]
    ) else $error("normalized mantissa lost its leading one");

endmodule

//--- hdl/vx_fcvt_pkg.sv
package vx_fcvt_pkg;

    // operand and tag widths of one request
    localparam int data_bits = 32;
    localparam int tag_bits  = 4;

    // width of a zero count over the operand, and the same plus one so that
    // the all-zero result (32) also fits
    localparam int lzc_bits = $clog2(data_bits);
    localparam int cnt_bits = lzc_bits + 1;

    // cycles from an accepted request to its response
    localparam int fcvt_latency = 2;

    typedef enum logic [1:0] {
        op_i2f_s = 2'd0,
        op_i2f_u = 2'd1,
        op_clz   = 2'd2,
        op_ctz   = 2'd3
    } fcvt_op_e;

    typedef struct packed {
        fcvt_op_e             op;
        logic [tag_bits-1:0]  tag;
        logic [data_bits-1:0] operand;
    } fcvt_req_t;

    // decoded controls, one copy per pipeline stage
    typedef struct packed {
        logic is_signed;
        logic is_count;
        logic reverse;
    } fcvt_ctl_t;

    // contents of the stage one register between normalize and round
    typedef struct packed {
        logic                 sign;
        logic                 zero;
        logic [lzc_bits-1:0]  lzc_cnt;
        logic [data_bits-1:0] mant;
        logic [cnt_bits-1:0]  count;
    } norm_t;

    typedef struct packed {
        logic [tag_bits-1:0]     tag;
        vx_fp_pkg::result_word_u data;
        logic                    inexact;
    } fcvt_rsp_t;

endpackage

//--- hdl/vx_fcvt_round.sv
`timescale 1ns/100ps

module vx_fcvt_round (
    input  logic                    clk,
    input  logic                    s1_valid,
    input  vx_fcvt_pkg::fcvt_ctl_t  ctl,
    input  vx_fcvt_pkg::norm_t      norm,
    output vx_fp_pkg::result_word_u rsp_data,
    output logic                    rsp_inexact
);

    import vx_fp_pkg::*;
    import vx_fcvt_pkg::*;

    logic [fp32_exp_bits-1:0]               exp_biased;
    logic [fp32_man_bits-1:0]               man_trunc;
    logic                                   guard;
    logic                                   sticky;
    logic                                   round_up;
    logic [fp32_exp_bits+fp32_man_bits-1:0] mag_rounded;
    result_word_u                           res_d;
    logic                                   inexact_d;

    // the leading one sits in the MSB, so its weight is 2**(31 - lzc count)
    assign exp_biased = fp32_exp_bits'(fp32_bias + data_bits - 1 - int'(norm.lzc_cnt));

    // 23 bits below the hidden one are kept, the next bit is the guard
    // and everything underneath collapses into sticky
    assign man_trunc = norm.mant[data_bits-2 -: fp32_man_bits];
    assign guard     = norm.mant[data_bits-2-fp32_man_bits];
    assign sticky    = |norm.mant[data_bits-3-fp32_man_bits:0];

    // nearest even rounds up above the halfway point, and on a tie only when
    // the kept LSB is odd
    assign round_up = guard & (sticky | man_trunc[0]);

    // exponent and fraction are added as one word so that a fraction overflow
    // carries into the exponent, 32 bits never reach the infinity encoding
    assign mag_rounded = {exp_biased, man_trunc} + (fp32_exp_bits + fp32_man_bits)'(round_up);

    always_comb begin
        res_d     = '0;
        inexact_d = 1'b0;
        if (ctl.is_count) begin
            // counts are exact integers read through the integer view
            res_d.ival = 32'(norm.count);
        end else if (!norm.zero) begin
            res_d.fval.sign = norm.sign;
            res_d.fval.exp  = mag_rounded[fp32_exp_bits+fp32_man_bits-1 -: fp32_exp_bits];
            res_d.fval.man  = mag_rounded[fp32_man_bits-1:0];
            inexact_d       = guard | sticky;
        end
        // a zero operand leaves +0 with no inexact flag
    end

    // response register, idle stages leave it untouched
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            rsp_data    <= res_d;
            rsp_inexact <= inexact_d;
        end
    end

endmodule

//--- hdl/vx_fcvt_unit.sv
`timescale 1ns/100ps

module vx_fcvt_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  vx_fcvt_pkg::fcvt_req_t req,
    output logic                   rsp_valid,
    output vx_fcvt_pkg::fcvt_rsp_t rsp
);

    import vx_fcvt_pkg::*;

    // decoded controls for the operand stage and for the register after it
    fcvt_ctl_t ctl_s0;
    fcvt_ctl_t ctl_s1;
    logic      s1_valid;
    // stage one register from normalize into round
    norm_t     norm;

    // valid, tag and control pipeline, also the owner of rsp_valid
    vx_fcvt_ctrl i_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_valid(req_valid),
        .req_op   (req.op),
        .req_tag  (req.tag),
        .ctl_s0   (ctl_s0),
        .s1_valid (s1_valid),
        .ctl_s1   (ctl_s1),
        .rsp_valid(rsp_valid),
        .rsp_tag  (rsp.tag)
    );

    // stage one datapath, magnitude and leading zero normalization
    vx_fcvt_norm i_norm (
        .clk     (clk),
        .s0_valid(req_valid),
        .operand (req.operand),
        .ctl     (ctl_s0),
        .norm    (norm)
    );

    // stage two datapath, rounding and result packing
    vx_fcvt_round i_round (
        .clk        (clk),
        .s1_valid   (s1_valid),
        .ctl        (ctl_s1),
        .norm       (norm),
        .rsp_data   (rsp.data),
        .rsp_inexact(rsp.inexact)
    );

endmodule

//--- hdl/vx_fp_pkg.sv
package vx_fp_pkg;

    // IEEE 754 single precision layout
    localparam int fp32_exp_bits = 8;
    localparam int fp32_man_bits = 23;

    // exponent bias, a biased exponent of bias encodes 2**0
    localparam int fp32_bias = 127;

    // one single precision word split into its three fields
    // the sign sits in the MSB and the fraction in the low bits
    typedef struct packed {
        logic                     sign;
        logic [fp32_exp_bits-1:0] exp;
        logic [fp32_man_bits-1:0] man;
    } fp32_t;

    // the result word of the unit is read in two ways
    // count operations deliver a plain integer in ival
    // conversions deliver a float and are packed through fval
    typedef union packed {
        logic [31:0] ival;
        fp32_t       fval;
    } result_word_u;

endpackage

//--- hdl/vx_lzc.sv
`timescale 1ns/100ps

module vx_lzc #(
    parameter int unsigned width = 2,
    // mode 1 counts from the MSB (leading), mode 0 from the LSB (trailing)
    parameter bit          mode  = 1'b0
) (
    input  logic [width-1:0]         in,
    output logic [$clog2(width)-1:0] cnt,
    output logic                     valid
);

    localparam int unsigned num_levels = $clog2(width);
    localparam int unsigned num_leaves = 2 ** num_levels;

    // a zero width vector has nothing to count and is refused at elaboration
    if (width == 0) begin : g_bad_width
        $error("vx_lzc needs an input of at least one bit");
    end

    if (num_levels > 0) begin : g_tree
        // search order, position 0 is the first bit looked at
        // positions beyond width are padding and never hold a one
        logic [num_leaves-1:0]                    in_ord;
        // heap layout, node n has children 2n+1 and 2n+2, leaves at the end
        logic [2*num_leaves-2:0]                  sel_node;
        logic [2*num_leaves-2:0][num_levels-1:0]  idx_node;

        always_comb begin
            in_ord = '0;
            for (int unsigned i = 0; i < width; i++) begin
                in_ord[i] = mode ? in[width-1-i] : in[i];
            end
        end

        // every leaf knows its own position in the search order
        for (genvar i = 0; i < num_leaves; i++) begin : g_leaf
            assign sel_node[num_leaves-1+i] = in_ord[i];
            assign idx_node[num_leaves-1+i] = num_levels'(i);
        end

        // each node passes up the left child when it holds a one, since the
        // left side lies earlier in the search order
        for (genvar n = 0; n < num_leaves - 1; n++) begin : g_node
            assign sel_node[n] = sel_node[2*n+1] | sel_node[2*n+2];
            assign idx_node[n] = sel_node[2*n+1] ? idx_node[2*n+1] : idx_node[2*n+2];
        end

        // the root holds the first one found, valid stays low for all zeros
        assign cnt   = idx_node[0];
        assign valid = sel_node[0];
    end else begin : g_single
        // a one bit input has no count to report, only its valid
        assign cnt   = '0;
        assign valid = in[0];
    end

endmodule

//--- tests/vx_fcvt_tb.sv
`timescale 1ns/100ps

module vx_fcvt_tb;

    import vx_fcvt_pkg::*;

    localparam int clk_period = 4;
    localparam int wait_limit = 100;
    // a request driven on one rising edge is seen on the negedge after two more edges
    localparam longint rsp_delay = fcvt_latency * clk_period + clk_period / 2;

    // one directed entry of op, operand and the result the unit must return
    typedef struct packed {
        fcvt_op_e    op;
        logic [31:0] operand;
        logic [31:0] data;
        logic        inexact;
    } vec_t;

    // a response still owed by the DUT, with the time its request was driven
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [31:0]         data;
        logic                inexact;
        logic [63:0]         issued;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    fcvt_req_t req;
    logic      rsp_valid;
    fcvt_rsp_t rsp;

    expect_t             expected[$];
    logic [tag_bits-1:0] next_tag;
    int                  checks;
    int                  errors;
    int                  err_start;

    // ties round to even, 0xffffffff carries into the exponent
    vec_t directed [14] = '{
        '{op_i2f_s, 32'h0000_0000, 32'h0000_0000, 1'b0},
        '{op_i2f_s, 32'h0000_0001, 32'h3f80_0000, 1'b0},
        '{op_i2f_s, 32'hffff_ffff, 32'hbf80_0000, 1'b0},
        '{op_i2f_s, 32'h8000_0000, 32'hcf00_0000, 1'b0},
        '{op_i2f_s, 32'h0100_0001, 32'h4b80_0000, 1'b1},
        '{op_i2f_s, 32'h0100_0003, 32'h4b80_0002, 1'b1},
        '{op_i2f_u, 32'hffff_ffff, 32'h4f80_0000, 1'b1},
        '{op_i2f_u, 32'h00ff_ffff, 32'h4b7f_ffff, 1'b0},
        '{op_clz,   32'h0000_0000, 32'd32,        1'b0},
        '{op_ctz,   32'h0000_0000, 32'd32,        1'b0},
        '{op_clz,   32'h0001_0000, 32'd15,        1'b0},
        '{op_ctz,   32'h0001_0000, 32'd16,        1'b0},
        '{op_clz,   32'h8000_0001, 32'd0,         1'b0},
        '{op_ctz,   32'h8000_0001, 32'd0,         1'b0}
    };

    vx_fcvt_unit i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_valid(req_valid),
        .req      (req),
        .rsp_valid(rsp_valid),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // reference model built from the conversion rules with integer arithmetic
    task automatic predict(input fcvt_op_e op, input logic [31:0] a,
                           output logic [31:0] data, output logic inexact);
        logic        neg;
        logic [31:0] mag;
        logic [31:0] kept;
        logic [31:0] rem;
        logic [31:0] half;
        int          msb;
        int          shift;
        int          bexp;
        data    = '0;
        inexact = 1'b0;
        if (op == op_clz) begin
            // the highest one written last decides the leading count
            data = 32;
            for (int i = 0; i < 32; i++) begin
                if (a[i]) data = 31 - i;
            end
        end else if (op == op_ctz) begin
            data = 32;
            for (int i = 31; i >= 0; i--) begin
                if (a[i]) data = i;
            end
        end else begin
            neg = (op == op_i2f_s) && a[31];
            mag = neg ? (32'd0 - a) : a;
            if (mag != 0) begin
                msb = 0;
                for (int i = 0; i < 32; i++) begin
                    if (mag[i]) msb = i;
                end
                bexp = 127 + msb;
                kept = mag << (23 - msb);
                if (msb > 23) begin
                    // drop the low bits and round half to even on what is left
                    shift   = msb - 23;
                    kept    = mag >> shift;
                    rem     = mag & ((32'd1 << shift) - 1);
                    half    = 32'd1 << (shift - 1);
                    inexact = (rem != 0);
                    if (rem > half || (rem == half && kept[0])) kept = kept + 1;
                    if (kept == 32'h0100_0000) begin
                        kept = kept >> 1;
                        bexp = bexp + 1;
                    end
                end
                data = {neg, 8'(bexp), kept[22:0]};
            end
        end
    endtask

    // drive one request on the next rising edge and queue what must come back
    task automatic send(input fcvt_op_e op, input logic [31:0] operand,
                        input logic [31:0] data, input logic inexact);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{op: op, tag: next_tag, operand: operand};
        expected.push_back('{tag: next_tag, data: data, inexact: inexact, issued: $time});
        next_tag++;
    endtask

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    // wait until every queued response has been checked, bounded by wait_limit
    task automatic drain(input string name);
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (expected.size() != 0) begin
            errors++;
            $display("%s: the response for tag %0d never arrived", name, expected[0].tag);
            expected.delete();
        end
    endtask

    task automatic run_random(input int count, input int max_gap);
        logic [1:0]  op_sel;
        logic [31:0] operand;
        logic [31:0] data;
        logic        inexact;
        for (int i = 0; i < count; i++) begin
            op_sel  = 2'($urandom_range(0, 3));
            operand = $urandom >> $urandom_range(0, 31);
            // inverting a short value gives large and negative operands too
            if ($urandom_range(0, 3) == 0) operand = ~operand;
            predict(fcvt_op_e'(op_sel), operand, data, inexact);
            send(fcvt_op_e'(op_sel), operand, data, inexact);
            if (max_gap > 0) idle(int'($urandom_range(1, max_gap)));
        end
    endtask

    task automatic report_test(input string name);
        if (errors == err_start) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - err_start);
        err_start = errors;
    endtask

    // responses are compared on the falling edge where the registered outputs are settled
    always @(negedge clk) begin : check_rsp
        expect_t exp_rsp;
        if (rst_n && rsp_valid) begin
            checks++;
            if (expected.size() == 0) begin
                errors++;
                $display("a response with tag %0d came with no request outstanding", rsp.tag);
            end else begin
                exp_rsp = expected.pop_front();
                if (rsp.tag !== exp_rsp.tag) begin
                    errors++;
                    $display("error at %0t ns: rsp.tag expected %h got %h",
                             $time, exp_rsp.tag, rsp.tag);
                end
                if (rsp.data.ival !== exp_rsp.data) begin
                    errors++;
                    $display("error at %0t ns: rsp.data expected %h got %h",
                             $time, exp_rsp.data, rsp.data.ival);
                end
                if (rsp.inexact !== exp_rsp.inexact) begin
                    errors++;
                    $display("error at %0t ns: rsp.inexact expected %b got %b",
                             $time, exp_rsp.inexact, rsp.inexact);
                end
                if (longint'($time) - longint'(exp_rsp.issued) != rsp_delay) begin
                    errors++;
                    $display("error at %0t ns: rsp latency expected %0d got %0d", $time,
                             rsp_delay, longint'($time) - longint'(exp_rsp.issued));
                end
            end
        end
    end

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        next_tag  = '0;
        checks    = 0;
        errors    = 0;
        err_start = 0;
        void'($urandom(32'h15df));
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // nothing may come out of an empty pipeline, then one request round trip
        @(negedge clk);
        checks++;
        if (rsp_valid !== 1'b0) begin
            errors++;
            $display("error at %0t ns: rsp_valid expected 0 got %b", $time, rsp_valid);
        end
        send(op_i2f_s, 32'h0000_0001, 32'h3f80_0000, 1'b0);
        idle(1);
        drain("single");
        report_test("single");

        foreach (directed[i]) begin
            send(directed[i].op, directed[i].operand, directed[i].data, directed[i].inexact);
        end
        idle(1);
        drain("directed");
        report_test("directed");

        run_random(40, 0);
        idle(1);
        drain("back_to_back");
        report_test("back_to_back");

        // idle cycles between requests let the monitor catch a stray rsp_valid
        run_random(12, 4);
        idle(4);
        drain("gaps");
        report_test("gaps");

        $display("%0d responses checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- vx_fcvt.f
hdl/vx_fp_pkg.sv
hdl/vx_fcvt_pkg.sv
hdl/vx_lzc.sv
hdl/vx_fcvt_ctrl.sv
hdl/vx_fcvt_norm.sv
hdl/vx_fcvt_round.sv
hdl/vx_fcvt_unit.sv
tests/vx_fcvt_tb.sv
